// ==== Bender.yml ====
package:
  name: ram512k

sources:
  - verilog/ram512k_pkg.sv
  - verilog/cpu_bus_if.sv
  - verilog/bank_select_reg.sv
  - verilog/write_cycle_fsm.sv
  - verilog/bank_mapper.sv
  - verilog/ram512k_top.sv
  - target: test
    files:
      - tests/ram512k_assertions.sv
      - tests/ram512k_tb.sv

// ==== files.f ====
verilog/ram512k_pkg.sv
verilog/cpu_bus_if.sv
verilog/bank_select_reg.sv
verilog/write_cycle_fsm.sv
verilog/bank_mapper.sv
verilog/ram512k_top.sv
tests/ram512k_assertions.sv
tests/ram512k_tb.sv

// ==== tests/ram512k_assertions.sv ====
// Concurrent checks on SRAM select gating, RD* overdrive and write-cycle length
`timescale 1ns/1ps

module ram512k_assertions (
  input logic       clk,
  input logic       reset_b,
  input logic       mreq_b,
  input logic       rfsh_b,
  input logic       ready,
  input logic [1:0] dip,
  input logic       mwr_cyc,
  input logic       ramcs_b,
  input logic       rd_b_drive
);

  logic ready_seen;
  int   mwr_len;
  int   wait_len;

  // Copy of the registered READY, plus counts of the current write cycle and its wait states
  always_ff @(posedge clk) begin
    if (!reset_b) begin
      ready_seen <= 1'b1;
      mwr_len    <= 0;
      wait_len   <= 0;
    end else begin
      ready_seen <= ready;
      mwr_len    <= mwr_cyc ? mwr_len + 1 : 0;
      if (!mwr_cyc) begin
        wait_len <= 0;
      end else if (!ready_seen) begin
        wait_len <= wait_len + 1;
      end
    end
  end

  // The SRAM stays deselected outside real memory cycles and during refresh
  assert property (@(posedge clk) disable iff (!reset_b) (mreq_b || !rfsh_b) |-> ramcs_b)
    else $error("ramcs_b low outside a memory cycle");

  // RD* is only ever overdriven when the board runs in overdrive mode
  assert property (@(posedge clk) disable iff (!reset_b) rd_b_drive |-> dip[0])
    else $error("rd_b_drive high with overdrive mode off");

  // One T1, one T2 and one extra T1 per wait state, never more
  assert property (@(posedge clk) disable iff (!reset_b)
                   mwr_cyc |-> (mwr_len <= wait_len + int'(!ready_seen) + 1))
    else $error("mwr_cyc held longer than the wait states allow");

endmodule

// ==== tests/ram512k_tb.sv ====
// Directed testbench that checks the 512K RAM expansion controller against a reference mapping
`timescale 1ns/1ps

module ram512k_tb;

  // Number of clock cycles that all tests together take at most
  localparam int test_cycles = 800;

  logic        clk, reset_b, rfsh_b, mreq_b, iorq_b, wr_b, rd_b, ramrd_b;
  logic        adr15, adr14, ready, m1_b;
  logic [7:0]  data;
  logic [1:0]  dip;
  logic        ramcs_b, ramdis, ramoe_b, ramwe_b, adr15_drive, rd_b_drive;
  logic [4:0]  ramadrhi;
  // Mapping that the select register should hold as tracked by the testbench
  logic [2:0]  cur_bank, cur_scheme;

  ram512k_top ram512k_top_i (.*);

  bind ram512k_top ram512k_assertions ram512k_assertions_i (.*);

  always #20 clk = ~clk;

  // Steps to just past the next rising edge where inputs are driven
  task automatic next_cycle(input int n = 1);
    repeat (n) @(posedge clk);
    #2;
  endtask

  task automatic check_equal(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Fail at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
      $display("** FAIL **");
      $fatal(1, "Stopping at the first mismatch");
    end
  endtask

  // Returns the internal select followed by the SRAM high address
  function automatic logic [5:0] ref_map(input logic [2:0] bnk, input logic [2:0] sch,
                                         input logic shadow, input logic [1:0] a,
                                         input logic [1:0] aq, input logic wr);
    logic       hit;
    logic [1:0] blk;
    logic [2:0] hb;
    logic       sel_b;
    logic [4:0] hi;
    hit = 1'b0;
    blk = a;
    if (sch == 3'd1) begin
      hit = (a == 2'b11);
      blk = 2'b11;
    end else if (sch == 3'd2) begin
      hit = 1'b1;
    end else if (sch == 3'd3) begin
      hit = (aq == 2'b11);
      blk = 2'b11;
    end else if (sch >= 3'd4) begin
      hit = (a == 2'b01);
      blk = 2'(sch - 3'd4);
    end
    // Bank 7 is the shadow bank so with shadowing on it falls back to bank 6
    hb    = (shadow && bnk == 3'd7) ? 3'd6 : bnk;
    sel_b = 1'b1;
    hi    = 5'd0;
    if (hit) begin
      sel_b = 1'b0;
      hi    = {hb, blk};
    end else if (shadow && sch == 3'd3 && aq == 2'b01) begin
      sel_b = 1'b0;
      hi    = {3'd7, 2'b11};
    end else if (shadow) begin
      sel_b = wr;
      hi    = {3'd7, a};
    end
    return {sel_b, hi};
  endfunction

  // One I/O write cycle that changes the tracked mapping only for a good tag with A15 low
  task automatic select_write(input logic [1:0] tag, input logic a15,
                              input logic [2:0] bnk, input logic [2:0] sch);
    {iorq_b, wr_b, adr15, data} = {1'b0, 1'b0, a15, tag, bnk, sch};
    next_cycle();
    {iorq_b, wr_b} = 2'b11;
    if (tag == 2'b11 && !a15) begin
      cur_bank   = bnk;
      cur_scheme = sch;
    end
  endtask

  // The address is set up with MREQ* high so the held A15 follows before MREQ* falls
  task automatic mem_access(input logic a15_v, input logic a14_v, input logic wr_v);
    logic [5:0] exp_map;
    {mreq_b, adr15, adr14, wr_b, rd_b, ramrd_b} = {1'b1, a15_v, a14_v, wr_v, !wr_v, !wr_v};
    next_cycle();
    mreq_b = 1'b0;
    #5;
    exp_map = ref_map(cur_bank, cur_scheme, dip[1], {a15_v, a14_v}, {a15_v, a14_v}, wr_v);
    check_equal("ramcs_b", ramcs_b, exp_map[5]);
    check_equal("ramdis", ramdis, !exp_map[5]);
    check_equal("ramoe_b", ramoe_b, !wr_v);
    check_equal("ramwe_b", ramwe_b, wr_v);
    if (!ramcs_b) begin
      check_equal("ramadrhi", ramadrhi, exp_map[4:0]);
    end
    next_cycle();
    mreq_b = 1'b1;
  endtask

  task automatic reset_outputs();
    // Overdrive on and a read with A14 high make a wrong register reset visible on the drives
    dip = 2'b01;
    {mreq_b, rd_b, adr14} = 3'b001;
    #5;
    check_equal("ramcs_b", ramcs_b, 1'b1);
    check_equal("ramdis", ramdis, 1'b0);
    check_equal("adr15_drive", adr15_drive, 1'b0);
    check_equal("rd_b_drive", rd_b_drive, 1'b0);
    next_cycle();
    for (int a = 0; a < 4; a++) begin
      mem_access(a[1], a[0], 1'b1);
    end
  endtask

  task automatic select_register();
    // A good tag with bank 5 and scheme 2 leaves the old mapping in place until the edge
    {iorq_b, wr_b, adr15, data} = {3'b000, 8'hea};
    #5;
    check_equal("ramdis", ramdis, 1'b0);
    next_cycle();
    {iorq_b, wr_b} = 2'b11;
    check_equal("ramdis", ramdis, 1'b1);
    cur_bank   = 3'd5;
    cur_scheme = 3'd2;
    mem_access(1'b0, 1'b0, 1'b1);
    select_write(2'b10, 1'b0, 3'd1, 3'd0);
    select_write(2'b11, 1'b1, 3'd1, 3'd0);
    mem_access(1'b1, 1'b0, 1'b1);
    // A refresh cycle never selects the SRAM even on a hit
    {rfsh_b, mreq_b} = 2'b00;
    #5;
    check_equal("ramcs_b", ramcs_b, 1'b1);
    next_cycle();
    {rfsh_b, mreq_b} = 2'b11;
  endtask

  // Each scheme is tried with one random bank and with bank 7 over all blocks and both directions
  task automatic mapping_sweep(input logic shadow);
    logic [2:0] bnk;
    dip = {shadow, 1'b0};
    for (int s = 0; s < 8; s++) begin
      for (int k = 0; k < 2; k++) begin
        bnk = (k == 0) ? 3'($urandom) : 3'd7;
        select_write(2'b11, 1'b0, bnk, 3'(s));
        for (int a = 0; a < 8; a++) begin
          mem_access(a[2], a[1], a[0]);
        end
      end
    end
  endtask

  // Holding READY low for the first waits edges stretches T1 by one cycle per edge
  task automatic write_overdrive(input int waits);
    int len;
    len = 0;
    dip = 2'b01;
    select_write(2'b11, 1'b0, 3'($urandom), 3'd2);
    {mreq_b, wr_b, rd_b, ready} = {1'b0, 1'b0, 1'b1, waits == 0};
    #5;
    check_equal("rd_b_drive", rd_b_drive, 1'b0);
    for (int k = 1; k < 20; k++) begin
      next_cycle();
      ready  = (k >= waits);
      mreq_b = (k > waits);
      #5;
      if (k == 1) begin
        check_equal("rd_b_drive", rd_b_drive, 1'b1);
      end
      if (rd_b_drive) begin
        len++;
      end else begin
        break;
      end
    end
    check_equal("rd_b_drive cycles", len, waits + 2);
    wr_b = 1'b1;
  endtask

  // A15 moves while MREQ* is low and the C3 decode must keep the held value
  task automatic a15_hold(input logic shadow);
    logic [5:0] exp_map;
    dip = {shadow, 1'b1};
    select_write(2'b11, 1'b0, 3'($urandom), 3'd3);
    {mreq_b, adr15, adr14, wr_b, rd_b} = 5'b11101;
    next_cycle();
    mreq_b = 1'b0;
    #5;
    // With shadowing the drive waits for the write cycle but without it MREQ* low is enough
    check_equal("adr15_drive", adr15_drive, !shadow);
    next_cycle();
    adr15 = 1'b0;
    #5;
    exp_map = ref_map(cur_bank, 3'd3, shadow, 2'b01, 2'b11, 1'b0);
    check_equal("ramcs_b", ramcs_b, exp_map[5]);
    check_equal("ramadrhi", ramadrhi, exp_map[4:0]);
    check_equal("adr15_drive", adr15_drive, 1'b1);
    next_cycle();
    mreq_b = 1'b1;
    next_cycle(2);
  endtask

  initial begin
    void'($urandom(32'hb026_fdfa));
    {clk, reset_b, rfsh_b, mreq_b, iorq_b, wr_b, rd_b, ramrd_b} = 8'b0011_1111;
    {adr15, adr14, ready, m1_b, data, dip} = {4'b0011, 8'h00, 2'b00};
    cur_bank   = 3'd0;
    cur_scheme = 3'd0;
    next_cycle(10);
    reset_b = 1'b1;
    reset_outputs();
    select_register();
    mapping_sweep(1'b0);
    mapping_sweep(1'b1);
    for (int n = 0; n < 4; n++) begin
      write_overdrive(n);
    end
    a15_hold(1'b0);
    a15_hold(1'b1);
    $display("** PASS **");
    $finish;
  end

  initial begin
    #(test_cycles * 40 + 2000);
    $display("Watchdog expired: the tests did not finish within their cycle budget");
    $display("** FAIL **");
    $fatal(1, "Timeout");
  end

endmodule

// ==== verilog/bank_mapper.sv ====
// Bank mapper that steers each access to SRAM or internal RAM and raises the overdrive requests
`timescale 1ns/1ps

module bank_mapper (
  input  logic                                clk,
  input  logic                                reset_b,
  cpu_bus_if.map                              bus,
  input  logic [ram512k_pkg::bank_w-1:0]      bank,
  input  logic [ram512k_pkg::scheme_w-1:0]    scheme,
  input  logic                                mwr_cyc,
  input  logic                                overdrive_mode,
  input  logic                                shadow_mode,
  output logic                                ramcs_b,
  output logic                                ramdis,
  output logic [ram512k_pkg::ramadr_hi_w-1:0] ramadrhi,
  output logic                                adr15_drive,
  output logic                                rd_b_drive
);
  import ram512k_pkg::*;

  logic              adr15_q;
  logic [1:0]        a;
  logic [1:0]        aq;
  logic [bank_w-1:0] hit_bank;
  logic [1:0]        blk;
  logic              exp_ram;
  logic              int_sel_b;

  // A15 follows the bus between cycles and is frozen once MREQ* falls
  // In C3 mode the board may overdrive A15 mid-cycle, so the decode must not see that change
  always_ff @(posedge clk) begin
    if (!reset_b) begin
      adr15_q <= 1'b0;
    end else if (bus.mreq_b) begin
      adr15_q <= bus.adr15;
    end
  end

  assign a  = {bus.adr15, bus.adr14};
  assign aq = {adr15_q, bus.adr14};

  // With shadowing on, the shadow bank is taken, so a select of it lands on the even bank below
  assign hit_bank = (shadow_mode && (bank == shadow_bank)) ? {bank[bank_w-1:1], 1'b0} : bank;

  // Work out whether the expansion RAM serves this access and which 16K block it uses
  always_comb begin
    exp_ram = 1'b0;
    blk     = a;
    case (scheme)
      3'd0: exp_ram = 1'b0;
      3'd1: begin
        exp_ram = (a == 2'b11);
        blk     = 2'b11;
      end
      3'd2: exp_ram = 1'b1;
      scheme_c3: begin
        // Uses the held A15 so an overdriven A15 does not move the access
        exp_ram = (aq == 2'b11);
        blk     = 2'b11;
      end
      // Schemes 4 to 7 place block 0 to 3 in the 0x4000 window
      default: begin
        exp_ram = (a == 2'b01);
        blk     = scheme[1:0];
      end
    endcase
  end

  // Choose the internal RAM select and the SRAM high address
  always_comb begin
    int_sel_b = 1'b1;
    ramadrhi  = {hit_bank, a};
    if (exp_ram) begin
      int_sel_b = 1'b0;
      ramadrhi  = {hit_bank, blk};
    end else if (shadow_mode) begin
      if ((scheme == scheme_c3) && (aq == 2'b01)) begin
        // Reads of the C3 window come from the shadow copy of block 3
        int_sel_b = 1'b0;
        ramadrhi  = {shadow_bank, 2'b11};
      end else begin
        // Writes to internal RAM are mirrored into the shadow bank, reads are not
        int_sel_b = bus.wr_b;
        ramadrhi  = {shadow_bank, a};
      end
    end
  end

  // SRAM is only enabled for real memory cycles, never during refresh
  assign ramcs_b = int_sel_b | bus.mreq_b | !bus.rfsh_b;

  // Disabling the internal RAM mirrors the SRAM select before the strobe gating
  assign ramdis  = !int_sel_b;

  // Pull A15 high for the C3 window; in shadow mode only writes need it, since reads come from SRAM
  assign adr15_drive = overdrive_mode && (scheme == scheme_c3) && bus.adr14 &&
                       (shadow_mode ? mwr_cyc : !bus.mreq_b);

  // Hold RD* off the internal RAM for the whole expansion write
  assign rd_b_drive = overdrive_mode && exp_ram && mwr_cyc;

endmodule

// ==== verilog/bank_select_reg.sv ====
// Bank and scheme select register, loaded by an I/O write to port 0x7Fxx
`timescale 1ns/1ps

module bank_select_reg (
  input  logic                              clk,
  input  logic                              reset_b,
  cpu_bus_if.cfg                            bus,
  output logic [ram512k_pkg::bank_w-1:0]    bank,
  output logic [ram512k_pkg::scheme_w-1:0]  scheme
);
  import ram512k_pkg::*;

  select_byte_t sel_byte;
  logic         sel_hit;

  // The same data byte is read both as a whole and as tag, bank and scheme
  assign sel_byte.raw = bus.data;

  // Port 0x7Fxx is decoded on A15 alone, the rest of the address is ignored
  // The tag check stops other devices sharing the port from changing the mapping
  assign sel_hit = !bus.iorq_b && !bus.wr_b && !bus.adr15 &&
                   (sel_byte.raw[7:6] == select_tag);

  // The new mapping takes effect in the cycle after the sampling edge
  always_ff @(posedge clk) begin
    if (!reset_b) begin
      bank   <= '0;
      scheme <= '0;
    end else if (sel_hit) begin
      bank   <= sel_byte.fields.bank;
      scheme <= sel_byte.fields.scheme;
    end
  end

endmodule

// ==== verilog/cpu_bus_if.sv ====
// Z80 CPU bus bundle shared by the select register, the write-cycle FSM and the mapper
`timescale 1ns/1ps

interface cpu_bus_if;

  // Memory and refresh strobes, all active low
  logic       mreq_b;
  logic       rfsh_b;
  logic       iorq_b;
  logic       wr_b;
  logic       rd_b;

  // Top two address bits choose the 16K block within the 64K space
  logic       adr15;
  logic       adr14;

  // Data bus, only read here during port writes
  logic [7:0] data;

  // Wait-state request from the bus, high when the cycle may proceed
  logic       ready;

  // Port decode view for the select register
  modport cfg (input iorq_b, input wr_b, input adr15, input data);

  // Cycle tracking view for the write-cycle FSM
  modport cycle (input mreq_b, input rfsh_b, input rd_b, input ready);

  // Address and strobe view for the bank mapper
  modport map (input mreq_b, input rfsh_b, input wr_b, input adr15, input adr14);

endinterface

// ==== verilog/ram512k_pkg.sv ====
// RAM expansion package with field widths, bank and scheme constants and the select byte layout
package ram512k_pkg;

  // Field widths of the select byte and of the SRAM high address
  localparam int tag_w       = 2;
  localparam int bank_w      = 3;
  localparam int scheme_w    = 3;

  // The SRAM high address is the bank followed by a two-bit block number
  localparam int ramadr_hi_w = bank_w + 2;

  // Bank reserved for shadowing the internal RAM
  localparam logic [bank_w-1:0] shadow_bank = 3'd7;

  // Top two bits of the data byte that mark a bank/scheme select write
  localparam logic [tag_w-1:0] select_tag = 2'b11;

  // Scheme that maps block 3 into the 0x4000 window, kept in step with adr15_q
  localparam logic [scheme_w-1:0] scheme_c3 = 3'd3;

  // Write-cycle state encodings, T2 and the spare state differ from T1 and idle by one bit
  localparam int          state_w   = 2;
  localparam logic [1:0]  st_idle   = 2'b00;
  localparam logic [1:0]  st_t1     = 2'b01;
  localparam logic [1:0]  st_t2     = 2'b11;
  localparam logic [1:0]  st_finish = 2'b10;

  // The data bus seen at a port write, either as a plain byte or split into its fields
  typedef union packed {
    logic [7:0] raw;
    struct packed {
      // Must equal select_tag for the write to reach the register
      logic [tag_w-1:0]    tag;
      // Picks one of eight 64K banks in the SRAM
      logic [bank_w-1:0]   bank;
      // Picks the block-switching scheme within the bank
      logic [scheme_w-1:0] scheme;
    } fields;
  } select_byte_t;

endpackage

// ==== verilog/ram512k_top.sv ====
// Top level of the 512K RAM expansion controller for a Z80 home computer
`timescale 1ns/1ps

module ram512k_top (
  input  logic                                clk,
  input  logic                                reset_b,
  input  logic                                rfsh_b,
  input  logic                                mreq_b,
  input  logic                                iorq_b,
  input  logic                                wr_b,
  input  logic                                rd_b,
  input  logic                                ramrd_b,
  input  logic                                adr15,
  input  logic                                adr14,
  input  logic [7:0]                          data,
  input  logic                                ready,
  input  logic                                m1_b,
  input  logic [1:0]                          dip,
  output logic                                ramcs_b,
  output logic                                ramdis,
  output logic [ram512k_pkg::ramadr_hi_w-1:0] ramadrhi,
  output logic                                ramoe_b,
  output logic                                ramwe_b,
  output logic                                adr15_drive,
  output logic                                rd_b_drive
);
  import ram512k_pkg::*;

  logic [bank_w-1:0]   bank;
  logic [scheme_w-1:0] scheme;
  logic                mwr_cyc;
  logic                overdrive_mode;
  logic                shadow_mode;

  // m1_b is not decoded, the pin is kept so the board footprint stays the same

  // Board switches, overdrive is needed on machines whose internal RAM cannot be disabled
  assign overdrive_mode = dip[0];
  assign shadow_mode    = dip[1];

  // Gather the CPU bus pins for the blocks below
  cpu_bus_if cpu_bus ();

  assign cpu_bus.mreq_b = mreq_b;
  assign cpu_bus.rfsh_b = rfsh_b;
  assign cpu_bus.iorq_b = iorq_b;
  assign cpu_bus.wr_b   = wr_b;
  assign cpu_bus.rd_b   = rd_b;
  assign cpu_bus.adr15  = adr15;
  assign cpu_bus.adr14  = adr14;
  assign cpu_bus.data   = data;
  assign cpu_bus.ready  = ready;

  // SRAM strobes come straight from the bus, the chip select does the gating
  assign ramwe_b = wr_b;
  assign ramoe_b = ramrd_b;

  bank_select_reg bank_select_reg_i (
    .clk     (clk),
    .reset_b (reset_b),
    .bus     (cpu_bus.cfg),
    .bank    (bank),
    .scheme  (scheme)
  );

  write_cycle_fsm write_cycle_fsm_i (
    .clk     (clk),
    .reset_b (reset_b),
    .bus     (cpu_bus.cycle),
    .mwr_cyc (mwr_cyc)
  );

  bank_mapper bank_mapper_i (
    .clk            (clk),
    .reset_b        (reset_b),
    .bus            (cpu_bus.map),
    .bank           (bank),
    .scheme         (scheme),
    .mwr_cyc        (mwr_cyc),
    .overdrive_mode (overdrive_mode),
    .shadow_mode    (shadow_mode),
    .ramcs_b        (ramcs_b),
    .ramdis         (ramdis),
    .ramadrhi       (ramadrhi),
    .adr15_drive    (adr15_drive),
    .rd_b_drive     (rd_b_drive)
  );

endmodule

// ==== verilog/write_cycle_fsm.sv ====
// Write-cycle FSM that tracks a CPU memory write from MREQ* low until READY lets it finish
`timescale 1ns/1ps

module write_cycle_fsm (
  input  logic     clk,
  input  logic     reset_b,
  cpu_bus_if.cycle bus,
  output logic     mwr_cyc
);
  import ram512k_pkg::*;

  logic [state_w-1:0] state_q;
  logic [state_w-1:0] state_d;
  logic               ready_q;

  // READY is registered so a wait state is seen one edge after it is asserted
  always_ff @(posedge clk) begin
    if (!reset_b) begin
      ready_q <= 1'b1;
    end else begin
      ready_q <= bus.ready;
    end
  end

  // A memory cycle with RD* high and no refresh can only be a write
  // T1 stretches while wait states are inserted, T2 covers the final clock
  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: begin
        if (!bus.mreq_b && bus.rfsh_b && bus.rd_b) begin
          state_d = st_t1;
        end
      end
      st_t1: begin
        if (ready_q) begin
          state_d = st_t2;
        end
      end
      st_t2: state_d = st_idle;
      // The spare encoding is never entered, fall back to idle if it ever is
      st_finish: state_d = st_idle;
      default: state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!reset_b) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Held through T1 and T2 so the RD* overdrive lasts past the rising edge of MREQ*
  assign mwr_cyc = (state_q == st_t1) || (state_q == st_t2);

endmodule
